// File: rv_core.f
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_fetch_stage.sv
src/rv_decoder.sv
src/rv_decode_stage.sv
src/rv_regfile.sv
src/rv_execute_stage.sv
src/rv_core.sv
verif/rv_core_checks.sv
verif/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -f rv_core.f -o rv_core_sim \
  && ./obj_dir/rv_core_sim > sim.log 2>&1 \
  || echo "Simulation ended with an error status" >> sim.log

cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/rv_core_tb.sv
module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_isa_pkg::*;

  localparam logic [XLEN-1:0] BOOT_PC = 32'h0000_1000;
  localparam int N_FIXED     = 17;
  localparam int N_INSTR     = N_FIXED + 200;
  localparam int CYCLE_LIMIT = 4 * (N_INSTR + 8);

  logic            clk;
  logic            reset_n;
  logic            instr_valid_i;
  logic            instr_ready_o;
  logic [XLEN-1:0] instr_i;
  logic            retire_valid_o;
  logic            retire_ready_i;
  logic [XLEN-1:0] retire_pc_o;
  logic            retire_we_o;
  logic [4:0]      retire_rd_o;
  logic [XLEN-1:0] retire_data_o;
  int              retired;
  logic            fail;
  int              cycles;
  int              idx;
  logic [XLEN-1:0] prog [N_INSTR];

  rv_core #(.BOOT_PC(BOOT_PC)) u_dut (
    .clk            (clk),
    .reset_n        (reset_n),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_i        (instr_i),
    .retire_valid_o (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_pc_o    (retire_pc_o),
    .retire_we_o    (retire_we_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  rv_core_checks #(.BOOT_PC(BOOT_PC)) u_checks (
    .clk            (clk),
    .reset_n        (reset_n),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_i  (instr_ready_o),
    .instr_i        (instr_i),
    .retire_valid_i (retire_valid_o),
    .retire_ready_i (retire_ready_i),
    .retire_pc_i    (retire_pc_o),
    .retire_we_i    (retire_we_o),
    .retire_rd_i    (retire_rd_o),
    .retire_data_i  (retire_data_o),
    .retired_o      (retired),
    .fail_o         (fail)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // Instruction encoders
  // ----------------------------------------------------------------------
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input funct3_e f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input funct3_e f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] u_type(input opcode_e opc, input logic [19:0] imm,
      input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] random_instr();
    funct3_e    f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [6:0] f7;
    logic [11:0] imm;
    f3  = funct3_e'($urandom % 8);
    rd  = 5'($urandom % 8);
    rs1 = 5'($urandom % 8);
    rs2 = 5'($urandom % 8);
    f7  = ((f3 == F3_ADD || f3 == F3_SR) && ($urandom % 2 == 1)) ? 7'h20 : 7'h00;
    imm = 12'($urandom % 4096);
    if (f3 == F3_SLL) imm = {7'h00, imm[4:0]};
    if (f3 == F3_SR) imm = {(f7 == 7'h20) ? 7'h20 : 7'h00, imm[4:0]};
    case ($urandom % 4)
      0:       return r_type(f7, rs2, rs1, f3, rd);
      1:       return i_type(imm, rs1, f3, rd);
      2:       return u_type(LUI, 20'($urandom), rd);
      default: return u_type(AUIPC, 20'($urandom), rd);
    endcase
  endfunction

  task automatic build_program();
    // Dependent chain at distances 1 and 2
    prog[0]  = i_type(12'd5, 5'd0, F3_ADD, 5'd1);
    prog[1]  = i_type(-12'sd3, 5'd1, F3_ADD, 5'd2);
    prog[2]  = r_type(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3);
    prog[3]  = r_type(7'h20, 5'd3, 5'd2, F3_ADD, 5'd4);
    prog[4]  = r_type(7'h00, 5'd1, 5'd4, F3_SLT, 5'd5);
    prog[5]  = r_type(7'h00, 5'd1, 5'd4, F3_SLTU, 5'd6);
    prog[6]  = u_type(LUI, 20'h80000, 5'd7);
    prog[7]  = r_type(7'h20, 5'd5, 5'd7, F3_SR, 5'd1);
    prog[8]  = r_type(7'h00, 5'd5, 5'd7, F3_SR, 5'd2);
    prog[9]  = r_type(7'h00, 5'd5, 5'd1, F3_SLL, 5'd3);
    prog[10] = i_type(12'hfff, 5'd3, F3_XOR, 5'd4);
    prog[11] = i_type(12'h07f, 5'd4, F3_AND, 5'd5);
    prog[12] = i_type({7'h20, 5'd4}, 5'd7, F3_SR, 5'd6);
    // Write to x0, then read it back
    prog[13] = i_type(12'd7, 5'd1, F3_ADD, 5'd0);
    prog[14] = r_type(7'h00, 5'd0, 5'd0, F3_ADD, 5'd4);
    prog[15] = u_type(AUIPC, 20'h12345, 5'd5);
    prog[16] = 32'hffff_ffff;
    for (int i = N_FIXED; i < N_INSTR; i++) begin
      prog[i] = random_instr();
    end
  endtask

  always @(posedge fail) begin
    $display("Something failed");
    $fatal(1);
  end

  // Timeout counter
  always @(posedge clk) begin
    if (reset_n) cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: only %0d of %0d instructions retired", retired, N_INSTR);
      $display("Something failed");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(76633));
    clk            = 1'b0;
    reset_n        = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    retire_ready_i = 1'b0;
    cycles         = 0;
    idx            = 0;
    build_program();
    repeat (8) @(posedge clk);
    #2 reset_n = 1'b1;
    assert (!retire_valid_o && instr_ready_o)
    else begin
      $display("Core is not idle after reset");
      $display("Something failed");
      $fatal(1);
    end
    while (retired < N_INSTR) begin
      @(posedge clk);
      if (instr_valid_i && instr_ready_o) idx++;
      #2;
      instr_valid_i  = (idx < N_INSTR) && ($urandom % 4 != 0);
      instr_i        = (idx < N_INSTR) ? prog[idx] : '0;
      retire_ready_i = ($urandom % 4 != 0);
    end
    @(posedge clk);
    if (fail) begin
      $display("Something failed");
      $fatal(1);
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: verif/rv_core_checks.sv
module rv_core_checks #(
  parameter logic [rv_isa_pkg::XLEN-1:0] BOOT_PC = '0
) (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             instr_valid_i,
  input  logic                             instr_ready_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      instr_i,
  input  logic                             retire_valid_i,
  input  logic                             retire_ready_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      retire_pc_i,
  input  logic                             retire_we_i,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] retire_rd_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      retire_data_i,
  output int                               retired_o,
  output logic                             fail_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import rv_isa_pkg::*;

  logic [XLEN-1:0] model [32];
  logic [XLEN-1:0] expect_pc;
  logic [XLEN-1:0] pending [$];
  logic            hold_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] data_q;
  logic            we_q;
  logic [4:0]      rd_q;

  // Result per the RV32I rules on the model registers
  function automatic logic [XLEN-1:0] isa_result(input logic [XLEN-1:0] ins,
                                                 input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [6:0]      opc;
    a   = model[ins[19:15]];
    opc = ins[6:0];
    b   = (opc == OP) ? model[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
    if (opc == LUI) return {ins[31:12], 12'h000};
    if (opc == AUIPC) return pc + {ins[31:12], 12'h000};
    case (ins[14:12])
      3'b000:  return (opc == OP && ins[30]) ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return ins[30] ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic writes_rd(input logic [XLEN-1:0] ins);
    logic [6:0] opc;
    opc = ins[6:0];
    return (opc == OP || opc == OP_IMM || opc == LUI || opc == AUIPC) && ins[11:7] != 5'd0;
  endfunction

  always @(posedge clk or negedge reset_n) begin
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] exp_data;
    logic            exp_we;
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) begin
        model[i] = '0;
      end
      expect_pc = BOOT_PC;
      retired_o = 0;
      fail_o    = 1'b0;
      hold_q    = 1'b0;
      pending.delete();
    end else begin
      // Outputs must not move while the retire port is stalled
      if (hold_q) begin
        assert (retire_valid_i && retire_pc_i == pc_q && retire_data_i == data_q
                && retire_we_i == we_q && retire_rd_i == rd_q)
        else begin
          $display("[ERROR] retire port changed under back-pressure: pc %h->%h data %h->%h",
                   pc_q, retire_pc_i, data_q, retire_data_i);
          fail_o = 1'b1;
        end
      end
      hold_q = retire_valid_i && !retire_ready_i;
      pc_q   = retire_pc_i;
      data_q = retire_data_i;
      we_q   = retire_we_i;
      rd_q   = retire_rd_i;
      if (retire_valid_i && retire_ready_i) begin
        assert (pending.size() > 0)
        else begin
          $display("Retirement seen without any accepted instruction");
          fail_o = 1'b1;
        end
        if (pending.size() > 0) begin
          ins      = pending.pop_front();
          exp_we   = writes_rd(ins);
          exp_data = isa_result(ins, expect_pc);
          assert (retire_pc_i == expect_pc)
          else begin
            $display("[ERROR] retire_pc_o got %h expected %h", retire_pc_i, expect_pc);
            fail_o = 1'b1;
          end
          assert (retire_we_i == exp_we)
          else begin
            $display("[ERROR] retire_we_o got %h expected %h", retire_we_i, exp_we);
            fail_o = 1'b1;
          end
          assert (!exp_we || (retire_rd_i == ins[11:7] && retire_data_i == exp_data))
          else begin
            $display("[ERROR] retire_data_o got %h expected %h (rd %h, instr %h)",
                     retire_data_i, exp_data, retire_rd_i, ins);
            fail_o = 1'b1;
          end
          if (exp_we) model[ins[11:7]] = exp_data;
          expect_pc = expect_pc + 32'd4;
          retired_o = retired_o + 1;
        end
      end
      if (instr_valid_i && instr_ready_i) pending.push_back(instr_i);
    end
  end

endmodule

// File: src/rv_core.sv
module rv_core #(
  parameter logic [rv_isa_pkg::XLEN-1:0] BOOT_PC = '0
) (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             instr_valid_i,
  output logic                             instr_ready_o,
  input  logic [rv_isa_pkg::XLEN-1:0]      instr_i,
  output logic                             retire_valid_o,
  input  logic                             retire_ready_i,
  output logic [rv_isa_pkg::XLEN-1:0]      retire_pc_o,
  output logic                             retire_we_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] retire_rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]      retire_data_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic                 pipe_en;
  logic                 rf_we;
  logic                 f_valid;
  logic [XLEN-1:0]      f_instr;
  logic [XLEN-1:0]      f_pc;
  logic [REG_ADR_W-1:0] rs1_adr;
  logic [REG_ADR_W-1:0] rs2_adr;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic                 d_valid;
  logic [XLEN-1:0]      d_pc;
  logic                 d_rd_v;
  logic [REG_ADR_W-1:0] d_rd_adr;
  logic [XLEN:0]        d_rs1_qual;
  logic [XLEN:0]        d_rs2_qual;
  unit_e                d_unit;
  alu_op_e              d_operation;
  logic                 exe_ff_write_v;
  logic [REG_ADR_W-1:0] exe_ff_rd_adr;
  logic [XLEN-1:0]      exe_ff_res_data;

  // Whole pipe advances unless a retiring result is stalled
  assign pipe_en = ~retire_valid_o | retire_ready_i;
  assign rf_we   = retire_valid_o & retire_ready_i & retire_we_o;

  rv_fetch_stage #(.BOOT_PC(BOOT_PC)) u_fetch (
    .clk           (clk),
    .reset_n       (reset_n),
    .pipe_en_i     (pipe_en),
    .instr_valid_i (instr_valid_i),
    .instr_ready_o (instr_ready_o),
    .instr_i       (instr_i),
    .f_valid_o     (f_valid),
    .f_instr_o     (f_instr),
    .f_pc_o        (f_pc)
  );

  rv_decode_stage u_decode (
    .clk               (clk),
    .reset_n           (reset_n),
    .pipe_en_i         (pipe_en),
    .f_valid_i         (f_valid),
    .f_instr_i         (f_instr),
    .f_pc_i            (f_pc),
    .rfr_rs1_adr_o     (rs1_adr),
    .rf_rs1_data_i     (rs1_data),
    .rfr_rs2_adr_o     (rs2_adr),
    .rf_rs2_data_i     (rs2_data),
    .exe_ff_write_v_i  (exe_ff_write_v),
    .exe_ff_rd_adr_i   (exe_ff_rd_adr),
    .exe_ff_res_data_i (exe_ff_res_data),
    .rf_ff_write_v_i   (retire_we_o),
    .rf_ff_rd_adr_i    (retire_rd_o),
    .rf_ff_res_data_i  (retire_data_o),
    .d_valid_o         (d_valid),
    .d_pc_o            (d_pc),
    .d_rd_v_o          (d_rd_v),
    .d_rd_adr_o        (d_rd_adr),
    .d_rs1_qual_o      (d_rs1_qual),
    .d_rs2_qual_o      (d_rs2_qual),
    .d_unit_o          (d_unit),
    .d_operation_o     (d_operation)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_adr_i  (rs1_adr),
    .rs1_data_o (rs1_data),
    .rs2_adr_i  (rs2_adr),
    .rs2_data_o (rs2_data),
    .we_i       (rf_we),
    .rd_adr_i   (retire_rd_o),
    .rd_data_i  (retire_data_o)
  );

  rv_execute_stage u_execute (
    .clk               (clk),
    .reset_n           (reset_n),
    .pipe_en_i         (pipe_en),
    .d_valid_i         (d_valid),
    .d_pc_i            (d_pc),
    .d_rd_v_i          (d_rd_v),
    .d_rd_adr_i        (d_rd_adr),
    .d_rs1_qual_i      (d_rs1_qual),
    .d_rs2_qual_i      (d_rs2_qual),
    .d_unit_i          (d_unit),
    .d_operation_i     (d_operation),
    .exe_ff_write_v_o  (exe_ff_write_v),
    .exe_ff_rd_adr_o   (exe_ff_rd_adr),
    .exe_ff_res_data_o (exe_ff_res_data),
    .retire_valid_o    (retire_valid_o),
    .retire_pc_o       (retire_pc_o),
    .retire_we_o       (retire_we_o),
    .retire_rd_o       (retire_rd_o),
    .retire_data_o     (retire_data_o)
  );

endmodule

// File: src/rv_execute_stage.sv
module rv_execute_stage (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             pipe_en_i,
  input  logic                             d_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      d_pc_i,
  input  logic                             d_rd_v_i,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] d_rd_adr_i,
  input  logic [rv_isa_pkg::XLEN:0]        d_rs1_qual_i,
  input  logic [rv_isa_pkg::XLEN:0]        d_rs2_qual_i,
  input  rv_pipe_pkg::unit_e               d_unit_i,
  input  rv_pipe_pkg::alu_op_e             d_operation_i,
  output logic                             exe_ff_write_v_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] exe_ff_rd_adr_o,
  output logic [rv_isa_pkg::XLEN-1:0]      exe_ff_res_data_o,
  output logic                             retire_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]      retire_pc_o,
  output logic                             retire_we_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] retire_rd_o,
  output logic [rv_isa_pkg::XLEN-1:0]      retire_data_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [XLEN:0]   sum;
  logic [XLEN-1:0] op1;
  logic [4:0]      shamt;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] shift_res;
  logic [XLEN-1:0] result;

  // ----------------------------------------------------------------------
  // ALU
  // ----------------------------------------------------------------------
  assign sum   = d_rs1_qual_i + d_rs2_qual_i;
  assign op1   = d_rs1_qual_i[XLEN-1:0];
  assign shamt = d_rs2_qual_i[4:0];

  always_comb begin
    case (d_operation_i)
      OP_ADD:  alu_res = sum[XLEN-1:0];
      // Sign of the 33-bit difference
      OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, sum[XLEN]};
      OP_AND:  alu_res = op1 & d_rs2_qual_i[XLEN-1:0];
      OP_OR:   alu_res = op1 | d_rs2_qual_i[XLEN-1:0];
      OP_XOR:  alu_res = op1 ^ d_rs2_qual_i[XLEN-1:0];
      default: alu_res = d_rs2_qual_i[XLEN-1:0];
    endcase
  end

  always_comb begin
    case (d_operation_i)
      OP_SLL:  shift_res = op1 << shamt;
      OP_SRA:  shift_res = $signed(op1) >>> shamt;
      default: shift_res = op1 >> shamt;
    endcase
  end

  always_comb begin
    case (d_unit_i)
      UNIT_ALU:   result = alu_res;
      UNIT_SHIFT: result = shift_res;
      default:    result = '0;
    endcase
  end

  assign exe_ff_write_v_o  = d_rd_v_i;
  assign exe_ff_rd_adr_o   = d_rd_adr_i;
  assign exe_ff_res_data_o = result;

  // Result register, also the writeback point
  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      retire_valid_o <= 1'b0;
      retire_we_o    <= 1'b0;
    end else if (pipe_en_i) begin
      retire_valid_o <= d_valid_i;
      retire_we_o    <= d_rd_v_i && (d_rd_adr_i != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_en_i) begin
      retire_pc_o   <= d_pc_i;
      retire_rd_o   <= d_rd_adr_i;
      retire_data_o <= result;
    end
  end

  a_reset_idle: assert property (@(posedge clk) !reset_n |-> !retire_valid_o);

  a_retire_hold: assert property (@(posedge clk) disable iff (!reset_n)
    retire_valid_o && !pipe_en_i |=> retire_valid_o && $stable(retire_pc_o)
      && $stable(retire_we_o) && $stable(retire_rd_o) && $stable(retire_data_o));

endmodule

// File: src/rv_regfile.sv
module rv_regfile (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] rs1_adr_i,
  output logic [rv_isa_pkg::XLEN-1:0]      rs1_data_o,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] rs2_adr_i,
  output logic [rv_isa_pkg::XLEN-1:0]      rs2_data_o,
  input  logic                             we_i,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] rd_adr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      rd_data_i
);
  import rv_isa_pkg::*;

  // x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_adr_i != '0)) begin
      regs[rd_adr_i] <= rd_data_i;
    end
  end

  assign rs1_data_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
  assign rs2_data_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];

endmodule

// File: src/rv_decode_stage.sv
module rv_decode_stage (
  input  logic                             clk,
  input  logic                             reset_n,
  input  logic                             pipe_en_i,
  // ----------------------------------------------------------------------
  // Fetch and register file side
  // ----------------------------------------------------------------------
  input  logic                             f_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      f_instr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      f_pc_i,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] rfr_rs1_adr_o,
  input  logic [rv_isa_pkg::XLEN-1:0]      rf_rs1_data_i,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] rfr_rs2_adr_o,
  input  logic [rv_isa_pkg::XLEN-1:0]      rf_rs2_data_i,
  // Forwarding sources
  input  logic                             exe_ff_write_v_i,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] exe_ff_rd_adr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      exe_ff_res_data_i,
  input  logic                             rf_ff_write_v_i,
  input  logic [rv_isa_pkg::REG_ADR_W-1:0] rf_ff_rd_adr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]      rf_ff_res_data_i,
  // ----------------------------------------------------------------------
  // Execute side
  // ----------------------------------------------------------------------
  output logic                             d_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]      d_pc_o,
  output logic                             d_rd_v_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] d_rd_adr_o,
  output logic [rv_isa_pkg::XLEN:0]        d_rs1_qual_o,
  output logic [rv_isa_pkg::XLEN:0]        d_rs2_qual_o,
  output rv_pipe_pkg::unit_e               d_unit_o,
  output rv_pipe_pkg::alu_op_e             d_operation_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic                 rd_v;
  logic [REG_ADR_W-1:0] rd_adr;
  logic                 rs1_v;
  logic                 rs2_v;
  logic                 auipc;
  logic                 rs2_is_immediat;
  logic [XLEN-1:0]      immediat;
  logic                 unsign_extension;
  unit_e                unit;
  alu_op_e              operation;
  logic                 rs2_ca2_v;
  logic                 exe_ff_rs1_match;
  logic                 exe_ff_rs2_match;
  logic                 rf_ff_rs1_match;
  logic                 rf_ff_rs2_match;
  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic [XLEN:0]        rs2_data_ext;

  rv_decoder u_decoder (
    .instr_i            (f_instr_i),
    .rd_v_o             (rd_v),
    .rd_o               (rd_adr),
    .rs1_v_o            (rs1_v),
    .rs1_adr_o          (rfr_rs1_adr_o),
    .rs2_v_o            (rs2_v),
    .rs2_adr_o          (rfr_rs2_adr_o),
    .auipc_o            (auipc),
    .rs2_is_immediat_o  (rs2_is_immediat),
    .immediat_o         (immediat),
    .unsign_extension_o (unsign_extension),
    .unit_o             (unit),
    .operation_o        (operation),
    .rs2_ca2_v_o        (rs2_ca2_v)
  );

  // Execute source wins over writeback, x0 never matches
  assign exe_ff_rs1_match = exe_ff_write_v_i && (exe_ff_rd_adr_i != '0)
                            && (exe_ff_rd_adr_i == rfr_rs1_adr_o);
  assign exe_ff_rs2_match = exe_ff_write_v_i && (exe_ff_rd_adr_i != '0)
                            && (exe_ff_rd_adr_i == rfr_rs2_adr_o);
  assign rf_ff_rs1_match  = rf_ff_write_v_i && (rf_ff_rd_adr_i != '0)
                            && (rf_ff_rd_adr_i == rfr_rs1_adr_o) && !exe_ff_rs1_match;
  assign rf_ff_rs2_match  = rf_ff_write_v_i && (rf_ff_rd_adr_i != '0)
                            && (rf_ff_rd_adr_i == rfr_rs2_adr_o) && !exe_ff_rs2_match;

  // Operand 1 is the PC for AUIPC
  always_comb begin
    if (auipc)                 rs1_data = f_pc_i;
    else if (!rs1_v)           rs1_data = '0;
    else if (exe_ff_rs1_match) rs1_data = exe_ff_res_data_i;
    else if (rf_ff_rs1_match)  rs1_data = rf_ff_res_data_i;
    else                       rs1_data = rf_rs1_data_i;
  end

  always_comb begin
    if (rs2_is_immediat)       rs2_data = immediat;
    else if (!rs2_v)           rs2_data = '0;
    else if (exe_ff_rs2_match) rs2_data = exe_ff_res_data_i;
    else if (rf_ff_rs2_match)  rs2_data = rf_ff_res_data_i;
    else                       rs2_data = rf_rs2_data_i;
  end

  assign rs2_data_ext = {~unsign_extension & rs2_data[XLEN-1], rs2_data};

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      d_valid_o <= 1'b0;
      d_rd_v_o  <= 1'b0;
    end else if (pipe_en_i) begin
      d_valid_o <= f_valid_i;
      d_rd_v_o  <= f_valid_i & rd_v;
    end
  end

  // Qualified 33-bit operands, negated operand 2 for SUB and SLT
  always_ff @(posedge clk) begin
    if (pipe_en_i) begin
      d_pc_o        <= f_pc_i;
      d_rd_adr_o    <= rd_adr;
      d_rs1_qual_o  <= {~unsign_extension & rs1_data[XLEN-1], rs1_data};
      d_rs2_qual_o  <= rs2_ca2_v ? (~rs2_data_ext + 1'b1) : rs2_data_ext;
      d_unit_o      <= unit;
      d_operation_o <= operation;
    end
  end

  // Forwarding sources hold while the pipe is frozen
  a_fwd_hold: assert property (@(posedge clk) disable iff (!reset_n)
    !pipe_en_i |=> $stable(exe_ff_write_v_i) && $stable(exe_ff_rd_adr_i)
                   && $stable(exe_ff_res_data_i) && $stable(rf_ff_write_v_i)
                   && $stable(rf_ff_rd_adr_i) && $stable(rf_ff_res_data_i));

endmodule

// File: src/rv_decoder.sv
module rv_decoder (
  input  logic [rv_isa_pkg::XLEN-1:0]      instr_i,
  output logic                             rd_v_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] rd_o,
  output logic                             rs1_v_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] rs1_adr_o,
  output logic                             rs2_v_o,
  output logic [rv_isa_pkg::REG_ADR_W-1:0] rs2_adr_o,
  output logic                             auipc_o,
  output logic                             rs2_is_immediat_o,
  output logic [rv_isa_pkg::XLEN-1:0]      immediat_o,
  output logic                             unsign_extension_o,
  output rv_pipe_pkg::unit_e               unit_o,
  output rv_pipe_pkg::alu_op_e             operation_o,
  output logic                             rs2_ca2_v_o
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  opcode_e opcode;
  funct3_e funct3;
  logic    is_op;

  assign opcode    = opcode_e'(instr_i[6:0]);
  assign funct3    = funct3_e'(instr_i[14:12]);
  assign is_op     = (opcode == OP);
  assign rd_o      = instr_i[11:7];
  assign rs1_adr_o = instr_i[19:15];
  assign rs2_adr_o = instr_i[24:20];

  always_comb begin
    rd_v_o             = 1'b0;
    rs1_v_o            = 1'b0;
    rs2_v_o            = 1'b0;
    auipc_o            = 1'b0;
    rs2_is_immediat_o  = 1'b0;
    unsign_extension_o = 1'b0;
    rs2_ca2_v_o        = 1'b0;
    unit_o             = UNIT_NONE;
    operation_o        = OP_PASS;
    // I-type by default, U-type for LUI and AUIPC
    immediat_o         = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
    case (opcode)
      OP, OP_IMM: begin
        rd_v_o            = 1'b1;
        rs1_v_o           = 1'b1;
        rs2_v_o           = is_op;
        rs2_is_immediat_o = ~is_op;
        unit_o            = UNIT_ALU;
        case (funct3)
          F3_ADD: begin
            operation_o = OP_ADD;
            rs2_ca2_v_o = is_op & instr_i[30];
          end
          F3_SLT: begin
            operation_o = OP_SLT;
            rs2_ca2_v_o = 1'b1;
          end
          F3_SLTU: begin
            operation_o        = OP_SLT;
            rs2_ca2_v_o        = 1'b1;
            unsign_extension_o = 1'b1;
          end
          F3_XOR: operation_o = OP_XOR;
          F3_OR:  operation_o = OP_OR;
          F3_AND: operation_o = OP_AND;
          F3_SLL: begin
            unit_o      = UNIT_SHIFT;
            operation_o = OP_SLL;
          end
          default: begin
            unit_o      = UNIT_SHIFT;
            operation_o = instr_i[30] ? OP_SRA : OP_SRL;
          end
        endcase
      end
      LUI, AUIPC: begin
        rd_v_o            = 1'b1;
        auipc_o           = (opcode == AUIPC);
        rs2_is_immediat_o = 1'b1;
        immediat_o        = {instr_i[31:12], 12'b0};
        unit_o            = UNIT_ALU;
        operation_o       = (opcode == AUIPC) ? OP_ADD : OP_PASS;
      end
      default: ;
    endcase
  end

endmodule

// File: src/rv_fetch_stage.sv
module rv_fetch_stage #(
  parameter logic [rv_isa_pkg::XLEN-1:0] BOOT_PC = '0
) (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         pipe_en_i,
  input  logic                         instr_valid_i,
  output logic                         instr_ready_o,
  input  logic [rv_isa_pkg::XLEN-1:0]  instr_i,
  output logic                         f_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]  f_instr_o,
  output logic [rv_isa_pkg::XLEN-1:0]  f_pc_o
);
  import rv_isa_pkg::*;

  logic            f_valid_q;
  logic [XLEN-1:0] f_instr_q;
  logic [XLEN-1:0] f_pc_q;
  logic [XLEN-1:0] next_pc_q;
  logic            accept;

  // An empty fetch register may fill even while the pipe is frozen
  assign instr_ready_o = pipe_en_i | ~f_valid_q;
  assign accept        = instr_valid_i & instr_ready_o;

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      f_valid_q <= 1'b0;
      next_pc_q <= BOOT_PC;
    end else begin
      if (instr_ready_o) f_valid_q <= instr_valid_i;
      if (accept) next_pc_q <= next_pc_q + XLEN'(4);
    end
  end

  // Instruction word and its PC
  always_ff @(posedge clk) begin
    if (accept) begin
      f_instr_q <= instr_i;
      f_pc_q    <= next_pc_q;
    end
  end

  assign f_valid_o = f_valid_q;
  assign f_instr_o = f_instr_q;
  assign f_pc_o    = f_pc_q;

  // Held instruction must not move while decode is frozen
  a_fetch_hold: assert property (@(posedge clk) disable iff (!reset_n)
    f_valid_o && !pipe_en_i |=> $stable(f_instr_o) && $stable(f_pc_o));

endmodule

// File: src/rv_pipe_pkg.sv
package rv_pipe_pkg;

  localparam int NB_UNIT      = 2;
  localparam int NB_OPERATION = 4;

  // Execute path that produces the result
  typedef enum logic [NB_UNIT-1:0] {
    UNIT_NONE  = 2'd0,
    UNIT_ALU   = 2'd1,
    UNIT_SHIFT = 2'd2
  } unit_e;

  // ----------------------------------------------------------------------
  // ALU operations
  // SUB is OP_ADD with a negated operand 2, SLTU is OP_SLT zero extended
  // ----------------------------------------------------------------------
  typedef enum logic [NB_OPERATION-1:0] {
    OP_ADD  = 4'd0,
    OP_SLT  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLL  = 4'd5,
    OP_SRL  = 4'd6,
    OP_SRA  = 4'd7,
    OP_PASS = 4'd8
  } alu_op_e;

endpackage

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

  // RV32I data path width
  localparam int XLEN = 32;

  // Instruction field widths
  localparam int OPCODE_W  = 7;
  localparam int FUNCT3_W  = 3;
  localparam int REG_ADR_W = 5;

  // ----------------------------------------------------------------------
  // Major opcodes kept by this core
  // ----------------------------------------------------------------------
  typedef enum logic [OPCODE_W-1:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // ALU funct3 codes, shared by OP and OP-IMM
  typedef enum logic [FUNCT3_W-1:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

endpackage
